// File: run.sh
#!/bin/sh
# compiles the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module async_fifo_tb -f sources.f &&
  ./obj_dir/Vasync_fifo_tb | tee /dev/stderr | grep -q "All checks passed" &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }

// File: sources.f
src/fifo_pkg.sv
src/fifo_ram.sv
src/gray_sync.sv
src/wr_ptr_ctrl.sv
src/rd_ptr_ctrl.sv
src/async_fifo.sv
tb/async_fifo_tb.sv

// File: src/async_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module async_fifo #(
  parameter int DATA_WIDTH  = fifo_pkg::DEF_DATA_WIDTH,
  parameter int FIFO_DEPTH  = fifo_pkg::DEF_FIFO_DEPTH,
  parameter int FIFO_AFULL  = fifo_pkg::DEF_FIFO_AFULL,
  parameter int FIFO_AEMPTY = fifo_pkg::DEF_FIFO_AEMPTY
) (
  input  wire logic                  wr_clk,
  input  wire logic                  wr_rst_n,
  input  wire logic                  wr_en,
  input  wire logic [DATA_WIDTH-1:0] wr_data,
  input  wire logic                  rd_clk,
  input  wire logic                  rd_rst_n,
  input  wire logic                  rd_en,
  output logic      [DATA_WIDTH-1:0] rd_data,
  output logic                       full,
  output logic                       afull,
  output logic                       empty,
  output logic                       aempty
);

  // depth must be a power of two for the Gray pointers to wrap cleanly
  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

  logic                  ram_wr_en;
  logic [ADDR_WIDTH-1:0] ram_wr_addr;
  logic                  ram_rd_en;
  logic [ADDR_WIDTH-1:0] ram_rd_addr;
  logic [ADDR_WIDTH:0]   wr_gray;
  logic [ADDR_WIDTH:0]   rd_gray;
  logic [ADDR_WIDTH:0]   wr_gray_sync;
  logic [ADDR_WIDTH:0]   rd_gray_sync;
  fifo_pkg::wr_status_t  wr_status;
  fifo_pkg::rd_status_t  rd_status;

  fifo_ram #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) fifo_ram_i (
    .wr_clk   (wr_clk),
    .wr_en    (ram_wr_en),
    .wr_addr  (ram_wr_addr),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (ram_rd_en),
    .rd_addr  (ram_rd_addr),
    .rd_data  (rd_data)
  );

  wr_ptr_ctrl #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .FIFO_AFULL (FIFO_AFULL)
  ) wr_ptr_ctrl_i (
    .wr_clk       (wr_clk),
    .wr_rst_n     (wr_rst_n),
    .wr_en        (wr_en),
    .rd_gray_sync (rd_gray_sync),
    .ram_wr_en    (ram_wr_en),
    .ram_wr_addr  (ram_wr_addr),
    .wr_gray      (wr_gray),
    .wr_status    (wr_status)
  );

  rd_ptr_ctrl #(
    .ADDR_WIDTH  (ADDR_WIDTH),
    .FIFO_AEMPTY (FIFO_AEMPTY)
  ) rd_ptr_ctrl_i (
    .rd_clk       (rd_clk),
    .rd_rst_n     (rd_rst_n),
    .rd_en        (rd_en),
    .wr_gray_sync (wr_gray_sync),
    .ram_rd_en    (ram_rd_en),
    .ram_rd_addr  (ram_rd_addr),
    .rd_gray      (rd_gray),
    .rd_status    (rd_status)
  );

  // write pointer into the read domain
  gray_sync #(
    .PTR_WIDTH (ADDR_WIDTH + 1)
  ) wr2rd_sync_i (
    .clk      (rd_clk),
    .rst_n    (rd_rst_n),
    .gray_in  (wr_gray),
    .gray_out (wr_gray_sync)
  );

  // read pointer into the write domain
  gray_sync #(
    .PTR_WIDTH (ADDR_WIDTH + 1)
  ) rd2wr_sync_i (
    .clk      (wr_clk),
    .rst_n    (wr_rst_n),
    .gray_in  (rd_gray),
    .gray_out (rd_gray_sync)
  );

  assign full   = wr_status.full;
  assign afull  = wr_status.afull;
  assign empty  = rd_status.empty;
  assign aempty = rd_status.aempty;

endmodule

`default_nettype wire

// File: src/fifo_pkg.sv
`default_nettype none

package fifo_pkg;

  // default geometry, overridden from the top level parameters
  localparam int DEF_DATA_WIDTH  = 8;
  localparam int DEF_FIFO_DEPTH  = 16;

  // thresholds in words, as seen from the side that owns the flag
  localparam int DEF_FIFO_AFULL  = 12;
  localparam int DEF_FIFO_AEMPTY = 2;

  // write side flags, registered in the wr_clk domain
  typedef struct packed {
    logic full;
    logic afull;
  } wr_status_t;

  // read side flags, registered in the rd_clk domain
  typedef struct packed {
    logic empty;
    logic aempty;
  } rd_status_t;

endpackage

`default_nettype wire

// File: src/fifo_ram.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_ram #(
  parameter int DATA_WIDTH = 8,
  parameter int ADDR_WIDTH = 4
) (
  input  wire logic                  wr_clk,
  input  wire logic                  wr_en,
  input  wire logic [ADDR_WIDTH-1:0] wr_addr,
  input  wire logic [DATA_WIDTH-1:0] wr_data,
  input  wire logic                  rd_clk,
  input  wire logic                  rd_rst_n,
  input  wire logic                  rd_en,
  input  wire logic [ADDR_WIDTH-1:0] rd_addr,
  output logic      [DATA_WIDTH-1:0] rd_data
);

  localparam int DEPTH = 1 << ADDR_WIDTH;

  typedef logic [DATA_WIDTH-1:0] word_t;

  word_t mem [DEPTH];

  // write port lives entirely in the wr_clk domain
  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read port, the word holds until the next accepted read
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// File: src/gray_sync.sv
`timescale 1ns/1ps
`default_nettype none

module gray_sync #(
  parameter int PTR_WIDTH = 5
) (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic [PTR_WIDTH-1:0] gray_in,
  output logic      [PTR_WIDTH-1:0] gray_out
);

  typedef logic [PTR_WIDTH-1:0] gray_t;

  // first stage may go metastable, only the second stage is used
  gray_t sync_q1;

  // a Gray pointer changes one bit per step, so a late sample is
  // either the old or the new value and never a mix of the two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q1 <= '0;
    end else begin
      sync_q1 <= gray_in;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gray_out <= '0;
    end else begin
      gray_out <= sync_q1;
    end
  end

endmodule

`default_nettype wire

// File: src/rd_ptr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rd_ptr_ctrl #(
  parameter int ADDR_WIDTH  = 4,
  parameter int FIFO_AEMPTY = 2
) (
  input  wire logic                  rd_clk,
  input  wire logic                  rd_rst_n,
  input  wire logic                  rd_en,
  input  wire logic [ADDR_WIDTH:0]   wr_gray_sync,
  output logic                       ram_rd_en,
  output logic      [ADDR_WIDTH-1:0] ram_rd_addr,
  output logic      [ADDR_WIDTH:0]   rd_gray,
  output fifo_pkg::rd_status_t       rd_status
);

  localparam int PTR_WIDTH = ADDR_WIDTH + 1;

  typedef logic [PTR_WIDTH-1:0] ptr_t;

  localparam ptr_t AEMPTY_LVL = ptr_t'(FIFO_AEMPTY);

  ptr_t rd_bin;
  ptr_t rd_bin_nxt;
  ptr_t rd_gray_nxt;
  ptr_t wr_bin_sync;
  ptr_t rd_avail_nxt;
  logic rd_accept;
  logic empty_nxt;
  logic aempty_nxt;

  // a read while empty is dropped here and never reaches the RAM
  assign rd_accept = rd_en & ~rd_status.empty;

  assign rd_bin_nxt  = rd_bin + ptr_t'(rd_accept);
  assign rd_gray_nxt = (rd_bin_nxt >> 1) ^ rd_bin_nxt;

  // the RAM register loads from the current pointer on the accepting edge
  assign ram_rd_en   = rd_accept;
  assign ram_rd_addr = rd_bin[ADDR_WIDTH-1:0];

  always_comb begin
    for (int i = 0; i < PTR_WIDTH; i++) begin
      wr_bin_sync[i] = ^(wr_gray_sync >> i);
    end
  end

  // words available as seen from the read side, low while the write pointer is in flight
  assign rd_avail_nxt = wr_bin_sync - rd_bin_nxt;

  // equal Gray codes mean equal pointers, no conversion needed for empty
  assign empty_nxt  = (rd_gray_nxt == wr_gray_sync);
  assign aempty_nxt = (rd_avail_nxt <= AEMPTY_LVL);

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin <= '0;
    end else begin
      rd_bin <= rd_bin_nxt;
    end
  end

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_gray <= '0;
    end else begin
      rd_gray <= rd_gray_nxt;
    end
  end

  // both flags read as set during reset, nothing is available yet
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_status.empty  <= 1'b1;
      rd_status.aempty <= 1'b1;
    end else begin
      rd_status.empty  <= empty_nxt;
      rd_status.aempty <= aempty_nxt;
    end
  end

endmodule

`default_nettype wire

// File: src/wr_ptr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module wr_ptr_ctrl #(
  parameter int ADDR_WIDTH = 4,
  parameter int FIFO_AFULL = 12
) (
  input  wire logic                  wr_clk,
  input  wire logic                  wr_rst_n,
  input  wire logic                  wr_en,
  input  wire logic [ADDR_WIDTH:0]   rd_gray_sync,
  output logic                       ram_wr_en,
  output logic      [ADDR_WIDTH-1:0] ram_wr_addr,
  output logic      [ADDR_WIDTH:0]   wr_gray,
  output fifo_pkg::wr_status_t       wr_status
);

  localparam int PTR_WIDTH = ADDR_WIDTH + 1;

  // pointers carry one extra bit to tell a full buffer from an empty one
  typedef logic [PTR_WIDTH-1:0] ptr_t;

  localparam ptr_t AFULL_LVL = ptr_t'(FIFO_AFULL);

  ptr_t wr_bin;
  ptr_t wr_bin_nxt;
  ptr_t wr_gray_nxt;
  ptr_t rd_bin_sync;
  ptr_t wr_used_nxt;
  logic wr_accept;
  logic full_nxt;
  logic afull_nxt;

  // the only place where a write is accepted or dropped
  assign wr_accept = wr_en & ~wr_status.full;

  assign wr_bin_nxt  = wr_bin + ptr_t'(wr_accept);
  assign wr_gray_nxt = (wr_bin_nxt >> 1) ^ wr_bin_nxt;

  assign ram_wr_en   = wr_accept;
  assign ram_wr_addr = wr_bin[ADDR_WIDTH-1:0];

  // each binary bit is the xor of all Gray bits at or above it
  always_comb begin
    for (int i = 0; i < PTR_WIDTH; i++) begin
      rd_bin_sync[i] = ^(rd_gray_sync >> i);
    end
  end

  // the read pointer seen here is stale, so the count errs high
  assign wr_used_nxt = wr_bin_nxt - rd_bin_sync;

  assign full_nxt  = (wr_bin_nxt[ADDR_WIDTH] != rd_bin_sync[ADDR_WIDTH]) &&
                     (wr_bin_nxt[ADDR_WIDTH-1:0] == rd_bin_sync[ADDR_WIDTH-1:0]);
  assign afull_nxt = (wr_used_nxt >= AFULL_LVL);

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin <= '0;
    end else begin
      wr_bin <= wr_bin_nxt;
    end
  end

  // Gray copy is registered so the synchronizer sees a glitch free bus
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_gray <= '0;
    end else begin
      wr_gray <= wr_gray_nxt;
    end
  end

  // flags come from the next pointer and so move on the same edge as the write
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_status.full  <= 1'b0;
      wr_status.afull <= 1'b0;
    end else begin
      wr_status.full  <= full_nxt;
      wr_status.afull <= afull_nxt;
    end
  end

endmodule

`default_nettype wire

// File: tb/async_fifo_tb.sv
`timescale 1ns/1ps
`default_nettype none

module async_fifo_tb;

  localparam int DATA_WIDTH  = fifo_pkg::DEF_DATA_WIDTH;
  localparam int FIFO_DEPTH  = fifo_pkg::DEF_FIFO_DEPTH;
  localparam int FIFO_AFULL  = fifo_pkg::DEF_FIFO_AFULL;
  localparam int FIFO_AEMPTY = fifo_pkg::DEF_FIFO_AEMPTY;

  localparam int RESET_CYCLES = 3;
  localparam int EXTRA_WRITES = 4;
  localparam int EXTRA_READS  = 4;
  localparam int SETTLE_LIMIT = 32;
  localparam int RAND_CYCLES  = 2000;
  localparam int MODEL_AW     = 12;

  // rd_clk is slower, one rd_clk cycle is counted as two wr_clk cycles
  localparam int DRAIN_CYCLES   = 2 * (SETTLE_LIMIT + FIFO_DEPTH + EXTRA_READS + 6);
  localparam int PHASE_CYCLES   = RESET_CYCLES + 5 + FIFO_DEPTH + 2 + EXTRA_WRITES +
                                  DRAIN_CYCLES + RAND_CYCLES + 1 + 10;
  localparam int TIMEOUT_CYCLES = 4 * PHASE_CYCLES;

  localparam logic [31:0] LFSR_SEED = 32'hb4e1;

  logic                  wr_clk   = 1'b0;
  logic                  rd_clk   = 1'b0;
  logic                  wr_rst_n = 1'b1;
  logic                  rd_rst_n = 1'b1;
  logic                  wr_en;
  logic                  rd_en;
  logic [DATA_WIDTH-1:0] wr_data;
  logic [DATA_WIDTH-1:0] rd_data;
  logic                  full;
  logic                  afull;
  logic                  empty;
  logic                  aempty;

  // reference queue kept as a ring, pushed in the wr_clk domain and popped in rd_clk
  logic [DATA_WIDTH-1:0] model_mem [1 << MODEL_AW];
  int                    push_cnt = 0;
  int                    pop_cnt  = 0;
  logic [DATA_WIDTH-1:0] exp_rd_data;

  // set while the flags of a side must match the model count exactly
  logic wr_exact;
  logic rd_exact;

  logic        rand_run;
  int          rand_cycle;
  logic [31:0] wr_lfsr;
  logic [31:0] rd_lfsr;

  int wr_errs   = 0;
  int rd_errs   = 0;
  int seq_errs  = 0;
  int wr_cycles = 0;

  always #10 wr_clk = ~wr_clk;
  always #13 rd_clk = ~rd_clk;

  async_fifo #(
    .DATA_WIDTH  (DATA_WIDTH),
    .FIFO_DEPTH  (FIFO_DEPTH),
    .FIFO_AFULL  (FIFO_AFULL),
    .FIFO_AEMPTY (FIFO_AEMPTY)
  ) async_fifo_i (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .afull    (afull),
    .empty    (empty),
    .aempty   (aempty)
  );

  // taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      state = lfsr_step(state);
      bits  = {bits[30:0], state[0]};
    end
  endtask

  task automatic report_counts();
    $display("error counts: write side %0d, read side %0d, sequence %0d",
             wr_errs, rd_errs, seq_errs);
  endtask

  always @(posedge wr_clk) begin : wr_monitor
    int   cnt;
    logic exp_full;
    logic exp_afull;
    cnt       = push_cnt - pop_cnt;
    exp_full  = (cnt == FIFO_DEPTH);
    exp_afull = (cnt >= FIFO_AFULL);
    if (!wr_rst_n) begin
      assert (!full && !afull) else begin
        wr_errs++;
        $display("Error: {full,afull} 0x%h expected 0x0 in reset", {full, afull});
      end
    end else begin
      // a stale read pointer can only hold full high longer, never raise it early
      assert (!full || cnt >= FIFO_AFULL) else begin
        wr_errs++;
        $display("full is high while the model holds only %0d words", cnt);
      end
      if (wr_exact) begin
        assert (full == exp_full) else begin
          wr_errs++;
          $display("Error: full 0x%h expected 0x%h at %0t", full, exp_full, $time);
        end
        assert (afull == exp_afull) else begin
          wr_errs++;
          $display("Error: afull 0x%h expected 0x%h at %0t", afull, exp_afull, $time);
        end
      end
      if (wr_en && !full) begin
        model_mem[push_cnt[MODEL_AW-1:0]] = wr_data;
        push_cnt++;
      end
    end
  end

  always @(posedge rd_clk) begin : rd_monitor
    int   cnt;
    logic exp_empty;
    logic exp_aempty;
    cnt        = push_cnt - pop_cnt;
    exp_empty  = (cnt == 0);
    exp_aempty = (cnt <= FIFO_AEMPTY);
    if (!rd_rst_n) begin
      assert (empty && aempty && rd_data == '0) else begin
        rd_errs++;
        $display("Error: {empty,aempty} 0x%h rd_data 0x%h expected 0x3 and 0x0 in reset",
                 {empty, aempty}, rd_data);
      end
      exp_rd_data = '0;
    end else begin
      // rd_data holds the word of the last accepted read
      assert (rd_data == exp_rd_data) else begin
        rd_errs++;
        $display("Error: rd_data 0x%h expected 0x%h at %0t", rd_data, exp_rd_data, $time);
      end
      assert (empty || cnt > 0) else begin
        rd_errs++;
        $display("empty is low while the model holds no words");
      end
      if (rd_exact) begin
        assert (empty == exp_empty) else begin
          rd_errs++;
          $display("Error: empty 0x%h expected 0x%h at %0t", empty, exp_empty, $time);
        end
        assert (aempty == exp_aempty) else begin
          rd_errs++;
          $display("Error: aempty 0x%h expected 0x%h at %0t", aempty, exp_aempty, $time);
        end
      end
      if (rd_en && !empty && cnt > 0) begin
        exp_rd_data = model_mem[pop_cnt[MODEL_AW-1:0]];
        pop_cnt++;
      end
    end
  end

  always @(posedge wr_clk) begin
    wr_cycles++;
    if (wr_cycles >= TIMEOUT_CYCLES) begin
      $display("run stopped after %0d wr_clk cycles without reaching the end", wr_cycles);
      report_counts();
      $display("Checks failed");
      $finish;
    end
  end

  task automatic fill_until_full();
    logic [31:0] bits;
    int          tries;
    tries = 0;
    @(negedge wr_clk);
    while (!full && tries < 2 * FIFO_DEPTH) begin
      draw_bits(wr_lfsr, DATA_WIDTH, bits);
      wr_en   = 1'b1;
      wr_data = bits[DATA_WIDTH-1:0];
      tries++;
      @(negedge wr_clk);
    end
    wr_en = 1'b0;
    assert (full) else begin
      seq_errs++;
      $display("full never rose while filling an idle FIFO");
    end
    assert (push_cnt == FIFO_DEPTH) else begin
      seq_errs++;
      $display("Error: accepted writes 0x%h expected 0x%h", push_cnt, FIFO_DEPTH);
    end
  endtask

  task automatic push_while_full();
    logic [31:0] bits;
    repeat (EXTRA_WRITES) begin
      draw_bits(wr_lfsr, DATA_WIDTH, bits);
      wr_en   = 1'b1;
      wr_data = bits[DATA_WIDTH-1:0];
      @(negedge wr_clk);
    end
    wr_en = 1'b0;
    assert (push_cnt == FIFO_DEPTH && full) else begin
      seq_errs++;
      $display("Error: accepted writes 0x%h full 0x%h expected 0x%h and 0x1",
               push_cnt, full, FIFO_DEPTH);
    end
  endtask

  task automatic drain_all();
    int waited;
    waited = 0;
    @(negedge rd_clk);
    while ((empty || aempty) && waited < SETTLE_LIMIT) begin
      @(negedge rd_clk);
      waited++;
    end
    assert (!empty && !aempty) else begin
      seq_errs++;
      $display("empty or aempty stayed high for %0d rd_clk cycles after the fill", waited);
    end
    // the write pointer has to be fully through the synchronizer
    repeat (4) @(negedge rd_clk);
    rd_exact = 1'b1;
    repeat (FIFO_DEPTH + EXTRA_READS) begin
      rd_en = 1'b1;
      @(negedge rd_clk);
    end
    rd_en = 1'b0;
    repeat (2) @(negedge rd_clk);
    assert (pop_cnt == push_cnt && empty) else begin
      seq_errs++;
      $display("Error: reads 0x%h empty 0x%h expected 0x%h and 0x1",
               pop_cnt, empty, push_cnt);
    end
    rd_exact = 1'b0;
  endtask

  // writes at one half, reads at one half and then three quarters of their clocks
  task automatic random_traffic();
    logic [31:0] wbits;
    logic [31:0] rbits;
    rand_run   = 1'b1;
    rand_cycle = 0;
    fork
      begin
        for (int c = 0; c < RAND_CYCLES; c++) begin
          @(negedge wr_clk);
          draw_bits(wr_lfsr, DATA_WIDTH + 1, wbits);
          wr_en      = wbits[DATA_WIDTH];
          wr_data    = wbits[DATA_WIDTH-1:0];
          rand_cycle = c;
        end
        @(negedge wr_clk);
        wr_en    = 1'b0;
        rand_run = 1'b0;
      end
      begin
        while (rand_run) begin
          @(negedge rd_clk);
          if (rand_cycle < RAND_CYCLES / 2) begin
            draw_bits(rd_lfsr, 1, rbits);
            rd_en = rbits[0];
          end else begin
            draw_bits(rd_lfsr, 2, rbits);
            rd_en = |rbits[1:0];
          end
        end
        rd_en = 1'b0;
      end
    join
  endtask

  initial begin
    wr_en    = 1'b0;
    rd_en    = 1'b0;
    wr_data  = '0;
    wr_exact = 1'b1;
    rd_exact = 1'b1;
    rand_run = 1'b0;
    wr_lfsr  = LFSR_SEED;
    rd_lfsr  = LFSR_SEED;
    #1;
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge wr_clk);
    @(negedge wr_clk);
    wr_rst_n = 1'b1;
    rd_rst_n = 1'b1;
    // both sides idle so the monitors see the reset flags right after release
    repeat (4) @(negedge wr_clk);
    rd_exact = 1'b0;
    fill_until_full();
    push_while_full();
    wr_exact = 1'b0;
    drain_all();
    random_traffic();
    repeat (10) @(negedge wr_clk);
    report_counts();
    if (wr_errs + rd_errs + seq_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
